// File: Makefile
TOP := tb_mycpu

all: run

build:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// File: build.f
verilog/la32_pkg.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/alu.sv
verilog/branch_unit.sv
verilog/cpu_control.sv
verilog/mycpu_top.sv
verification/tb_sram.sv
verification/tb_mycpu.sv

// File: verification/tb_mycpu.sv
`timescale 1ns/10ps

module tb_mycpu;
    import la32_pkg::*;

    localparam word_t       base_pc = 32'h1c00_0000;
    localparam logic [16:0] op_add  = 17'h00020;
    localparam logic [16:0] op_sub  = 17'h00022;
    localparam logic [16:0] op_slt  = 17'h00024;
    localparam logic [16:0] op_sltu = 17'h00025;
    localparam logic [16:0] op_nor  = 17'h00028;
    localparam logic [16:0] op_and  = 17'h00029;
    localparam logic [16:0] op_or   = 17'h0002a;
    localparam logic [16:0] op_xor  = 17'h0002b;
    localparam logic [16:0] op_slli = 17'h00081;
    localparam logic [16:0] op_srli = 17'h00089;
    localparam logic [16:0] op_srai = 17'h00091;
    localparam logic [9:0]  op_addi = 10'h00a;
    localparam logic [9:0]  op_ld   = 10'h0a2;
    localparam logic [9:0]  op_st   = 10'h0a6;

    logic      clk;
    logic      reset;
    word_t     inst_sram_addr, inst_sram_rdata;
    logic      data_sram_we;
    word_t     data_sram_addr, data_sram_wdata, data_sram_rdata;
    word_t     debug_wb_pc;
    logic      debug_wb_rf_we;
    reg_addr_t debug_wb_rf_wnum;
    word_t     debug_wb_rf_wdata;

    word_t      model_rf [32] = '{default: '0};
    word_t      model_mem [1024] = '{default: '0};
    word_t      lfsr_state = 32'h3a3d_35b7;
    int         n_inst = 0;
    logic       skip_next = 1'b0;                // Next word is branched over.
    logic [2:0] cur_test = 3'd1;
    word_t      exp_pc [$];
    reg_addr_t  exp_wnum [$];
    word_t      exp_wdata [$];
    logic [2:0] exp_test [$];
    word_t      exp_st_addr [$];
    word_t      exp_st_data [$];
    logic [2:0] exp_st_test [$];
    int         test_err [8] = '{default: 0};
    string      test_name [8] = '{"", "arithmetic", "shifts", "memory", "branches",
                                  "links", "r0", ""};
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         stray_errors = 0;
    int         cycles_after_reset = 0;

    mycpu_top i_mycpu_top (
        .clk, .reset, .inst_sram_addr, .inst_sram_rdata,
        .data_sram_we, .data_sram_addr, .data_sram_wdata, .data_sram_rdata,
        .debug_wb_pc, .debug_wb_rf_we, .debug_wb_rf_wnum, .debug_wb_rf_wdata
    );

    tb_sram i_inst_sram (
        .clk, .we (1'b0), .addr (inst_sram_addr), .wdata (32'h0), .rdata (inst_sram_rdata)
    );

    tb_sram i_data_sram (
        .clk,
        .we    (data_sram_we),
        .addr  (data_sram_addr),
        .wdata (data_sram_wdata),
        .rdata (data_sram_rdata)
    );

    function automatic word_t lfsr_next(input word_t s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic random_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Places one word and queues its register write unless it is jumped over.
    task automatic emit(input word_t w, input logic writes, input reg_addr_t rd,
                        input word_t value);
        if (writes && !skip_next) begin
            exp_pc.push_back(base_pc + 4 * n_inst);
            exp_wnum.push_back(rd);
            exp_wdata.push_back(value);
            exp_test.push_back(cur_test);
            if (rd != 5'd0) begin
                model_rf[rd] = value;
            end
        end
        skip_next = 1'b0;
        i_inst_sram.mem[n_inst[9:0]] <= w;
        n_inst++;
    endtask

    task automatic op3(input logic [16:0] op, input reg_addr_t rd, input reg_addr_t rj,
                       input reg_addr_t rk);
        word_t a;
        word_t b;
        word_t r;
        a = model_rf[rj];
        b = (op == op_slli || op == op_srli || op == op_srai) ? {27'b0, rk} : model_rf[rk];
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_slt:  r = {31'b0, $signed(a) < $signed(b)};
            op_sltu: r = {31'b0, a < b};
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_nor:  r = ~(a | b);
            op_xor:  r = a ^ b;
            op_slli: r = a << b[4:0];
            op_srli: r = a >> b[4:0];
            op_srai: r = (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'h0);
            default: r = '0;
        endcase
        emit({op, rk, rj, rd}, 1'b1, rd, r);
    endtask

    task automatic op2ri(input logic [9:0] op, input reg_addr_t rd, input reg_addr_t rj,
                         input logic [11:0] si12);
        word_t ea;
        ea = model_rf[rj] + {{20{si12[11]}}, si12};
        if (op == op_st) begin
            if (!skip_next) begin
                model_mem[ea[11:2]] = model_rf[rd];
                exp_st_addr.push_back(ea);
                exp_st_data.push_back(model_rf[rd]);
                exp_st_test.push_back(cur_test);
            end
            emit({op, si12, rj, rd}, 1'b0, rd, 32'h0);
        end else begin
            emit({op, si12, rj, rd}, 1'b1, rd, (op == op_ld) ? model_mem[ea[11:2]] : ea);
        end
    endtask

    task automatic lu12i(input reg_addr_t rd, input logic [19:0] si20);
        emit({7'h0a, si20, rd}, 1'b1, rd, {si20, 12'h000});
    endtask

    // Taken branches skip exactly one word.
    task automatic cond_branch(input logic is_ne, input reg_addr_t rj, input reg_addr_t rd);
        logic taken;
        taken = (model_rf[rj] != model_rf[rd]) == is_ne;
        emit({is_ne ? 6'h17 : 6'h16, 16'd2, rj, rd}, 1'b0, 5'd0, 32'h0);
        skip_next = taken;
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        word_t imm;
        word_t link_pc;
        random_bits(20, a);
        random_bits(20, b);
        a[19] = 1'b1;                            // r4 stays negative after the addi.
        a[0]  = 1'b1;
        b[19] = 1'b0;                            // r5 stays positive.
        b[18] = 1'b1;
        lu12i(5'd4, a[19:0]);
        random_bits(12, imm);
        op2ri(op_addi, 5'd4, 5'd4, imm[11:0]);
        lu12i(5'd5, b[19:0]);
        random_bits(12, imm);
        op2ri(op_addi, 5'd5, 5'd5, imm[11:0]);
        op3(op_add, 5'd6, 5'd4, 5'd5);
        op3(op_sub, 5'd7, 5'd4, 5'd5);
        op3(op_slt, 5'd8, 5'd4, 5'd5);
        op3(op_sltu, 5'd9, 5'd4, 5'd5);
        op3(op_and, 5'd13, 5'd4, 5'd5);
        op3(op_or, 5'd14, 5'd4, 5'd5);
        op3(op_nor, 5'd15, 5'd4, 5'd5);
        op3(op_xor, 5'd16, 5'd4, 5'd5);
        random_bits(12, imm);
        op2ri(op_addi, 5'd17, 5'd4, imm[11:0]);
        cur_test = 3'd2;
        op3(op_slli, 5'd19, 5'd4, 5'd0);
        op3(op_slli, 5'd20, 5'd4, 5'd31);
        op3(op_srli, 5'd21, 5'd4, 5'd0);
        op3(op_srli, 5'd22, 5'd4, 5'd31);
        op3(op_srai, 5'd23, 5'd4, 5'd31);
        op3(op_srai, 5'd24, 5'd4, 5'd0);
        op3(op_srai, 5'd25, 5'd4, 5'd7);
        cur_test = 3'd3;
        op2ri(op_addi, 5'd10, 5'd0, 12'h100);
        op2ri(op_st, 5'd6, 5'd10, 12'h000);
        op2ri(op_st, 5'd7, 5'd10, 12'h008);
        op2ri(op_ld, 5'd11, 5'd10, 12'h000);
        op2ri(op_ld, 5'd12, 5'd10, 12'h008);
        cur_test = 3'd4;
        cond_branch(1'b0, 5'd11, 5'd6);
        op2ri(op_addi, 5'd26, 5'd0, 12'h001);
        cond_branch(1'b0, 5'd4, 5'd5);
        op2ri(op_addi, 5'd26, 5'd0, 12'h002);
        cond_branch(1'b1, 5'd4, 5'd5);
        op2ri(op_addi, 5'd26, 5'd0, 12'h003);
        cond_branch(1'b1, 5'd12, 5'd7);
        op2ri(op_addi, 5'd26, 5'd0, 12'h004);
        emit({6'h14, 16'd2, 10'd0}, 1'b0, 5'd0, 32'h0);
        skip_next = 1'b1;
        op2ri(op_addi, 5'd27, 5'd0, 12'h055);
        op2ri(op_addi, 5'd28, 5'd0, 12'h0aa);
        cur_test = 3'd5;
        link_pc = base_pc + 4 * n_inst;
        emit({6'h15, 16'd2, 10'd0}, 1'b1, 5'd1, link_pc + 32'd4);      // bl to link_pc + 8.
        emit({6'h14, 16'd3, 10'd0}, 1'b0, 5'd0, 32'h0);                 // Return lands here.
        op2ri(op_addi, 5'd29, 5'd0, 12'h321);
        emit({6'h13, 16'd0, 5'd1, 5'd2}, 1'b1, 5'd2, link_pc + 32'd16); // jirl r2, r1, 0.
        cur_test = 3'd6;
        op2ri(op_addi, 5'd0, 5'd0, 12'h123);
        op3(op_add, 5'd30, 5'd0, 5'd4);
        emit({6'h14, 26'd0}, 1'b0, 5'd0, 32'h0);                        // Parks in place.
    endtask

    task automatic report_value(input string name, input word_t expected, input word_t actual,
                                input logic [2:0] t);
        $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        test_err[t]++;
    endtask

    task automatic close_test(input logic [2:0] t);
        if (test_err[t] == 0) begin
            tests_passed++;
            $display("test %0d %s: passed", t, test_name[t]);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", t, test_name[t], test_err[t]);
        end
    endtask

    task automatic check_write();
        logic [2:0] t;
        assert (exp_pc.size() > 0) else begin
            $display("Trace write to r%0d at %0t with no write expected", debug_wb_rf_wnum,
                     $time);
            stray_errors++;
        end
        if (exp_pc.size() > 0) begin
            t = exp_test[0];
            assert (debug_wb_pc == exp_pc[0])
                else report_value("debug_wb_pc", exp_pc[0], debug_wb_pc, t);
            assert (debug_wb_rf_wnum == exp_wnum[0])
                else report_value("debug_wb_rf_wnum", word_t'(exp_wnum[0]),
                                  word_t'(debug_wb_rf_wnum), t);
            assert (debug_wb_rf_wdata == exp_wdata[0])
                else report_value("debug_wb_rf_wdata", exp_wdata[0], debug_wb_rf_wdata, t);
            void'(exp_pc.pop_front());
            void'(exp_wnum.pop_front());
            void'(exp_wdata.pop_front());
            void'(exp_test.pop_front());
            if (exp_test.size() == 0 || exp_test[0] != t) begin
                close_test(t);
            end
        end
    endtask

    task automatic check_store();
        logic [2:0] t;
        assert (exp_st_addr.size() > 0) else begin
            $display("Data memory write to %h at %0t with no store expected", data_sram_addr,
                     $time);
            stray_errors++;
        end
        if (exp_st_addr.size() > 0) begin
            t = exp_st_test[0];
            assert (data_sram_addr == exp_st_addr[0])
                else report_value("data_sram_addr", exp_st_addr[0], data_sram_addr, t);
            assert (data_sram_wdata == exp_st_data[0])
                else report_value("data_sram_wdata", exp_st_data[0], data_sram_wdata, t);
            void'(exp_st_addr.pop_front());
            void'(exp_st_data.pop_front());
            void'(exp_st_test.pop_front());
        end
    endtask

    // Trace outputs settle after the rising edge, so they are sampled mid-cycle.
    always @(negedge clk) begin
        if (reset || cycles_after_reset < 3) begin
            assert (!debug_wb_rf_we) else begin
                $display("Trace write at %0t during reset or its first three cycles", $time);
                test_err[6]++;
            end
        end else if (debug_wb_rf_we) begin
            check_write();
        end
        if (data_sram_we) begin
            check_store();
        end
        if (reset) begin
            cycles_after_reset = 0;
        end else begin
            cycles_after_reset++;
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        @(negedge reset);
        #(n_inst * 5 * 8 * 2);
        $display("Watchdog expired before the program retired all expected writes");
        $display("Test failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        build_program();
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        while (exp_pc.size() != 0 || exp_st_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);                // Catch stray writes after the last test.
        $display("%0d tests passed, %0d tests with errors, %0d errors outside tests",
                 tests_passed, tests_failed, stray_errors);
        if (tests_failed == 0 && stray_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verification/tb_sram.sv
`timescale 1ns/10ps

module tb_sram #(
    parameter int addr_bits = 10
) (
    input  logic            clk,
    input  logic            we,
    input  la32_pkg::word_t addr,
    input  la32_pkg::word_t wdata,
    output la32_pkg::word_t rdata
);
    import la32_pkg::*;

    word_t mem [2**addr_bits] = '{default: '0};

    // Byte address in, word index out.
    always @(posedge clk) begin
        if (we) begin
            mem[addr[addr_bits+1:2]] <= wdata;
        end
    end

    assign rdata = mem[addr[addr_bits+1:2]];

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu (
    input  la32_pkg::alu_op_t alu_op,
    input  la32_pkg::word_t   src1,
    input  la32_pkg::word_t   src2,
    output la32_pkg::word_t   result
);
    import la32_pkg::*;

    word_t      sum;
    word_t      diff;
    logic       lt_signed;
    logic       lt_unsigned;
    logic [4:0] shamt;

    assign sum         = src1 + src2;
    assign diff        = src1 - src2;
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;
    assign shamt       = src2[4:0];

    always_comb begin
        result = '0;
        if (alu_op[alu_add])  result = result | sum;
        if (alu_op[alu_sub])  result = result | diff;
        if (alu_op[alu_slt])  result = result | {31'b0, lt_signed};
        if (alu_op[alu_sltu]) result = result | {31'b0, lt_unsigned};
        if (alu_op[alu_and])  result = result | (src1 & src2);
        if (alu_op[alu_nor])  result = result | ~(src1 | src2);
        if (alu_op[alu_or])   result = result | (src1 | src2);
        if (alu_op[alu_xor])  result = result | (src1 ^ src2);
        if (alu_op[alu_sll])  result = result | (src1 << shamt);
        if (alu_op[alu_srl])  result = result | (src1 >> shamt);
        if (alu_op[alu_sra])  result = result | word_t'($signed(src1) >>> shamt);
        if (alu_op[alu_lui])  result = result | src2;    // Immediate is already shifted.
    end

endmodule

// File: verilog/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
    input  la32_pkg::word_t pc,
    input  la32_pkg::word_t rj_value,
    input  la32_pkg::word_t rkd_value,
    input  la32_pkg::word_t br_offs,
    input  logic            is_beq,
    input  logic            is_bne,
    input  logic            is_jump,
    input  logic            is_jirl,
    output logic            br_taken,
    output la32_pkg::word_t br_target
);
    logic values_equal;

    assign values_equal = rj_value == rkd_value;

    assign br_taken = (is_beq & values_equal)
                    | (is_bne & ~values_equal)
                    | is_jump
                    | is_jirl;

    // jirl is register-relative, the rest are PC-relative.
    assign br_target = is_jirl ? rj_value + br_offs : pc + br_offs;

endmodule

// File: verilog/cpu_control.sv
`timescale 1ns/10ps

module cpu_control #(
    parameter la32_pkg::word_t reset_pc = 32'h1c00_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  la32_pkg::word_t     inst_sram_rdata,
    input  la32_pkg::word_t     data_sram_rdata,
    input  la32_pkg::word_t     alu_result,
    input  la32_pkg::word_t     br_target,
    input  la32_pkg::word_t     rkd_value,
    input  logic                br_taken,
    input  logic                ends_in_decode,
    input  logic                mem_we,
    input  logic                res_from_mem,
    input  logic                gr_we,
    input  la32_pkg::reg_addr_t dest,
    output la32_pkg::word_t     inst,
    output la32_pkg::word_t     pc,
    output la32_pkg::word_t     inst_sram_addr,
    output la32_pkg::word_t     data_sram_addr,
    output la32_pkg::word_t     data_sram_wdata,
    output logic                data_sram_we,
    output logic                rf_we,
    output la32_pkg::reg_addr_t rf_waddr,
    output la32_pkg::word_t     rf_wdata
);
    import la32_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;
    logic       br_taken_q;
    word_t      br_target_q;
    word_t      exec_result;
    word_t      load_data;
    word_t      seq_pc;
    word_t      next_pc;
    word_t      final_result;
    logic       pc_advance;

    always_comb begin
        state_next = state;
        case (state)
            state_fetch:     state_next = state_decode;
            state_decode:    state_next = ends_in_decode ? state_fetch : state_execute;
            state_execute:   state_next = (mem_we | res_from_mem) ? state_memory
                                                                  : state_writeback;
            state_memory:    state_next = res_from_mem ? state_writeback : state_fetch;
            state_writeback: state_next = state_fetch;
            default:         state_next = state_fetch;
        endcase
    end

    // PC moves on at the end of the last state of each instruction.
    assign pc_advance = (state == state_decode && ends_in_decode)
                     || (state == state_memory && !res_from_mem)
                     || (state == state_writeback);

    assign seq_pc = pc + 32'd4;

    // A branch ending in decode uses the live decision.
    assign next_pc = (state == state_decode) ? (br_taken ? br_target : seq_pc)
                                             : (br_taken_q ? br_target_q : seq_pc);

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= state_fetch;
            pc         <= reset_pc;
            br_taken_q <= 1'b0;
        end else begin
            state <= state_next;
            if (pc_advance) begin
                pc <= next_pc;
            end
            if (state == state_decode) begin
                br_taken_q <= br_taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == state_fetch) begin
            inst <= inst_sram_rdata;
        end
        if (state == state_decode) begin
            br_target_q <= br_target;
        end
        if (state == state_execute) begin
            exec_result <= alu_result;
        end
        if (state == state_memory) begin
            load_data <= data_sram_rdata;
        end
    end

    assign inst_sram_addr  = pc;
    assign data_sram_addr  = exec_result;       // Address from execute.
    assign data_sram_wdata = rkd_value;
    assign data_sram_we    = (state == state_memory) && mem_we;

    assign final_result = res_from_mem ? load_data : exec_result;

    assign rf_we    = (state == state_writeback) && gr_we;
    assign rf_waddr = dest;
    assign rf_wdata = final_result;

endmodule

// File: verilog/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  la32_pkg::word_t     inst,
    output la32_pkg::reg_addr_t rf_raddr1,
    output la32_pkg::reg_addr_t rf_raddr2,
    output la32_pkg::reg_addr_t dest,
    output la32_pkg::alu_op_t   alu_op,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output la32_pkg::word_t     imm,
    output la32_pkg::word_t     br_offs,
    output logic                is_beq,
    output logic                is_bne,
    output logic                is_jump,
    output logic                is_jirl,
    output logic                ends_in_decode,
    output logic                mem_we,
    output logic                res_from_mem,
    output logic                gr_we
);
    import la32_pkg::*;

    logic [16:0] op_3r;                          // inst[31:15].
    logic [9:0]  op_2ri;                         // inst[31:22].
    logic [5:0]  op_hi;                          // inst[31:26].
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic        inst_add_w, inst_sub_w, inst_slt, inst_sltu;
    logic        inst_nor, inst_and, inst_or, inst_xor;
    logic        inst_slli_w, inst_srli_w, inst_srai_w;
    logic        inst_addi_w, inst_lu12i_w, inst_ld_w, inst_st_w;
    logic        inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic        use_shamt;

    assign op_3r  = inst[31:15];
    assign op_2ri = inst[31:22];
    assign op_hi  = inst[31:26];
    assign rd     = inst[4:0];
    assign rj     = inst[9:5];
    assign rk     = inst[14:10];

    assign inst_add_w   = op_3r == 17'h00020;
    assign inst_sub_w   = op_3r == 17'h00022;
    assign inst_slt     = op_3r == 17'h00024;
    assign inst_sltu    = op_3r == 17'h00025;
    assign inst_nor     = op_3r == 17'h00028;
    assign inst_and     = op_3r == 17'h00029;
    assign inst_or      = op_3r == 17'h0002a;
    assign inst_xor     = op_3r == 17'h0002b;
    assign inst_slli_w  = op_3r == 17'h00081;
    assign inst_srli_w  = op_3r == 17'h00089;
    assign inst_srai_w  = op_3r == 17'h00091;
    assign inst_addi_w  = op_2ri == 10'h00a;
    assign inst_ld_w    = op_2ri == 10'h0a2;
    assign inst_st_w    = op_2ri == 10'h0a6;
    assign inst_lu12i_w = inst[31:25] == 7'h0a;
    assign inst_jirl    = op_hi == 6'h13;
    assign inst_b       = op_hi == 6'h14;
    assign inst_bl      = op_hi == 6'h15;
    assign inst_beq     = op_hi == 6'h16;
    assign inst_bne     = op_hi == 6'h17;

    assign alu_op[alu_add]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                            | inst_jirl | inst_bl;
    assign alu_op[alu_sub]  = inst_sub_w;
    assign alu_op[alu_slt]  = inst_slt;
    assign alu_op[alu_sltu] = inst_sltu;
    assign alu_op[alu_and]  = inst_and;
    assign alu_op[alu_nor]  = inst_nor;
    assign alu_op[alu_or]   = inst_or;
    assign alu_op[alu_xor]  = inst_xor;
    assign alu_op[alu_sll]  = inst_slli_w;
    assign alu_op[alu_srl]  = inst_srli_w;
    assign alu_op[alu_sra]  = inst_srai_w;
    assign alu_op[alu_lui]  = inst_lu12i_w;

    assign use_shamt = inst_slli_w | inst_srli_w | inst_srai_w;

    // Link instructions add 4 to the PC.
    assign imm = (inst_bl | inst_jirl) ? 32'd4 :
                 inst_lu12i_w          ? {inst[24:5], 12'b0} :
                                         {{20{inst[21]}}, inst[21:10]};

    assign br_offs = (inst_b | inst_bl) ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00} :
                                          {{14{inst[25]}}, inst[25:10], 2'b00};

    assign src1_is_pc  = inst_jirl | inst_bl;
    assign src2_is_imm = use_shamt | inst_addi_w | inst_ld_w | inst_st_w
                       | inst_lu12i_w | inst_jirl | inst_bl;

    assign rf_raddr1 = rj;
    assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;
    assign dest      = inst_bl ? 5'd1 : rd;

    assign is_beq         = inst_beq;
    assign is_bne         = inst_bne;
    assign is_jump        = inst_b | inst_bl;
    assign is_jirl        = inst_jirl;
    assign ends_in_decode = inst_b | inst_beq | inst_bne;
    assign mem_we         = inst_st_w;
    assign res_from_mem   = inst_ld_w;
    assign gr_we          = |alu_op & ~inst_st_w;   // Every ALU user but the store.

endmodule

// File: verilog/la32_pkg.sv
package la32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] alu_op_t;

    // Bit positions inside alu_op_t.
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef enum logic [2:0] {
        state_fetch,
        state_decode,
        state_execute,
        state_memory,
        state_writeback
    } cpu_state_t;

endpackage

// File: verilog/mycpu_top.sv
`timescale 1ns/10ps

module mycpu_top #(
    parameter la32_pkg::word_t reset_pc = 32'h1c00_0000
) (
    input  logic                clk,
    input  logic                reset,
    output la32_pkg::word_t     inst_sram_addr,
    input  la32_pkg::word_t     inst_sram_rdata,
    output logic                data_sram_we,
    output la32_pkg::word_t     data_sram_addr,
    output la32_pkg::word_t     data_sram_wdata,
    input  la32_pkg::word_t     data_sram_rdata,
    output la32_pkg::word_t     debug_wb_pc,
    output logic                debug_wb_rf_we,
    output la32_pkg::reg_addr_t debug_wb_rf_wnum,
    output la32_pkg::word_t     debug_wb_rf_wdata
);
    import la32_pkg::*;

    word_t     inst;
    word_t     pc;
    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    reg_addr_t dest;
    alu_op_t   alu_op;
    logic      src1_is_pc;
    logic      src2_is_imm;
    word_t     imm;
    word_t     br_offs;
    logic      is_beq, is_bne, is_jump, is_jirl;
    logic      ends_in_decode, mem_we, res_from_mem, gr_we;
    word_t     rj_value;
    word_t     rkd_value;
    word_t     alu_src1;
    word_t     alu_src2;
    word_t     alu_result;
    logic      br_taken;
    word_t     br_target;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    cpu_control #(
        .reset_pc (reset_pc)
    ) i_cpu_control (
        .clk, .reset, .inst_sram_rdata, .data_sram_rdata,
        .alu_result, .br_target, .rkd_value, .br_taken,
        .ends_in_decode, .mem_we, .res_from_mem, .gr_we, .dest,
        .inst, .pc, .inst_sram_addr,
        .data_sram_addr, .data_sram_wdata, .data_sram_we,
        .rf_we, .rf_waddr, .rf_wdata
    );

    inst_decoder i_inst_decoder (
        .inst, .rf_raddr1, .rf_raddr2, .dest, .alu_op,
        .src1_is_pc, .src2_is_imm, .imm, .br_offs,
        .is_beq, .is_bne, .is_jump, .is_jirl,
        .ends_in_decode, .mem_we, .res_from_mem, .gr_we
    );

    regfile i_regfile (
        .clk,
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    // Operand selects for the ALU.
    assign alu_src1 = src1_is_pc ? pc : rj_value;
    assign alu_src2 = src2_is_imm ? imm : rkd_value;

    alu i_alu (
        .alu_op,
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    branch_unit i_branch_unit (
        .pc, .rj_value, .rkd_value, .br_offs,
        .is_beq, .is_bne, .is_jump, .is_jirl,
        .br_taken, .br_target
    );

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: verilog/regfile.sv
`timescale 1ns/10ps

module regfile (
    input  logic                clk,
    input  la32_pkg::reg_addr_t raddr1,
    input  la32_pkg::reg_addr_t raddr2,
    input  logic                we,
    input  la32_pkg::reg_addr_t waddr,
    input  la32_pkg::word_t     wdata,
    output la32_pkg::word_t     rdata1,
    output la32_pkg::word_t     rdata2
);
    import la32_pkg::*;

    word_t rf [32];

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 may be written but always reads as zero.
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule
